/* verilog/spinePkg.sv */
package spinePkg;

	// what the decoder makes of an instruction
	typedef enum logic [1:0] {
		CLS_NORMAL,
		CLS_JUMP,
		CLS_ERET,
		CLS_SYSCALL
	} instrClass_t;

	// IF register contents, straight from the icache
	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fetchSlot_t;

	// carried from ID down to WB
	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		instrClass_t cls;
		logic exc;             // raised in ID, taken at MEM2
		logic [4:0] excCode;
		logic isBD;            // sits in a jump's delay slot
	} pipeInstr_t;

	typedef struct packed {
		logic ifWr;
		logic ifFlush;
		logic idWr;
		logic idFlush;
		logic exWr;
		logic exFlush;
		logic mem1Wr;
		logic mem1Flush;
		logic mem2Wr;
		logic mem2Flush;
		logic wbWr;
		logic wbFlush;
	} stageCtl_t;

	// cause codes as in CP0 Cause.ExcCode
	localparam logic [4:0] EXC_SYS = 5'd8;
	localparam logic [4:0] EXC_RI = 5'd10;

	localparam logic [31:0] DEFAULT_RESET_PC = 32'hbfc00000;
	localparam logic [31:0] DEFAULT_EXC_VECTOR = 32'hbfc00380;

endpackage

/* verilog/stageReg.sv */
`timescale 1ns/1ns

module stageReg #(
	parameter type payload_t = logic [31:0]
) (
	input logic clk,
	input logic reset,
	input logic wr,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	// flush beats wr, a squashed stage becomes an all-zero bubble
	always_ff @(posedge clk) begin
		if (reset || flush)
			q <= '0;
		else if (wr)
			q <= d;
	end

endmodule

/* verilog/nextPc.sv */
`timescale 1ns/1ns

module nextPc #(
	parameter logic [31:0] RESET_PC = 32'hbfc00000,
	parameter logic [31:0] EXC_VECTOR = 32'hbfc00380
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic icacheValid,
	input logic jumpRedirect,
	input logic [31:0] jumpTarget,
	input logic trapRedirect,
	input logic [31:0] trapTarget,
	output logic [31:0] fetchAddr
);

	logic [31:0] nextAddr;
	logic pcWr;

	// trap/eret first, then jump, else sequential
	always_comb begin
		if (trapRedirect)
			nextAddr = trapTarget;
		else if (jumpRedirect)
			nextAddr = jumpTarget;
		else
			nextAddr = fetchAddr + 32'd4;
	end

	// hold while the fetch is not accepted, unless redirected
	assign pcWr = advance && (trapRedirect || jumpRedirect || icacheValid);

	always_ff @(posedge clk) begin
		if (reset)
			fetchAddr <= RESET_PC;
		else if (pcWr)
			fetchAddr <= nextAddr;
	end

	// both vectors must be usable as fetch addresses
	initial begin
		assert (RESET_PC[1:0] == 2'b00 && EXC_VECTOR[1:0] == 2'b00)
			else $error("reset pc or exception vector not word aligned");
	end

	// jump targets, EPC and the vectors all have to keep this
	assert property (@(posedge clk) disable iff (reset) fetchAddr[1:0] == 2'b00)
		else $error("fetchAddr %h not word aligned", fetchAddr);

endmodule

/* verilog/instrDecode.sv */
`timescale 1ns/1ns

module instrDecode import spinePkg::*; (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic trapRedirect,
	input fetchSlot_t slot,
	input pipeInstr_t idInstr,
	output pipeInstr_t decoded,
	output logic jumpRedirect,
	output logic [31:0] jumpTarget
);

	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_J = 6'b000010;
	localparam logic [5:0] OP_COP0 = 6'b010000;
	localparam logic [5:0] OP_RES = 6'b111111;
	localparam logic [5:0] FN_SYSCALL = 6'b001100;
	localparam logic [5:0] FN_ERET = 6'b011000;

	logic inDelaySlot;   // last valid instr into ID was a jump
	logic reserved;
	instrClass_t cls;
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [31:0] pcPlus4;

	assign opcode = slot.instr[31:26];
	assign funct = slot.instr[5:0];
	assign pcPlus4 = slot.pc + 32'd4;

	always_comb begin
		cls = CLS_NORMAL;
		reserved = 1'b0;
		case (opcode)
			OP_J: cls = CLS_JUMP;
			OP_COP0: if (funct == FN_ERET) cls = CLS_ERET;
			OP_SPECIAL: if (funct == FN_SYSCALL) cls = CLS_SYSCALL;
			OP_RES: reserved = 1'b1;
			default: ;
		endcase
		// no control transfer allowed in a delay slot
		if (inDelaySlot && (cls == CLS_JUMP || cls == CLS_ERET)) begin
			cls = CLS_NORMAL;
			reserved = 1'b1;
		end
	end

	always_comb begin
		decoded.valid = slot.valid;
		decoded.pc = slot.pc;
		decoded.cls = cls;
		decoded.exc = reserved || cls == CLS_SYSCALL;
		decoded.excCode = reserved ? EXC_RI : (cls == CLS_SYSCALL ? EXC_SYS : 5'd0);
		decoded.isBD = inDelaySlot && slot.valid;
	end

	// a trap flush kills any jump still waiting for its delay slot
	always_ff @(posedge clk) begin
		if (reset || (advance && trapRedirect))
			inDelaySlot <= 1'b0;
		else if (advance && slot.valid)
			inDelaySlot <= cls == CLS_JUMP;
	end

	always_ff @(posedge clk) begin
		if (advance && slot.valid && cls == CLS_JUMP)
			jumpTarget <= {pcPlus4[31:28], slot.instr[25:0], 2'b00};
	end

	// redirect once the delay slot is in IF since the jump may have moved on
	assign jumpRedirect = inDelaySlot && slot.valid;

	// only bubbles may follow the pending jump into ID before its delay slot
	assert property (@(posedge clk) disable iff (reset)
		inDelaySlot |-> !idInstr.valid || idInstr.cls == CLS_JUMP)
		else $error("delay slot record out of step with the ID register");

endmodule

/* verilog/pipeControl.sv */
`timescale 1ns/1ns

module pipeControl import spinePkg::*; (
	input logic clk,
	input logic reset,
	input logic memStall,
	input logic icacheValid,
	input logic jumpRedirect,
	input logic trapRedirect,
	output stageCtl_t ctl,
	output logic advance,
	output logic ifBubble
);

	logic trapFlush;

	// one global stall, the whole pipe freezes on data back-pressure
	assign advance = !memStall;
	assign trapFlush = advance && trapRedirect;

	// no fetch this cycle, or the fetch is the one after a delay slot
	assign ifBubble = !icacheValid || jumpRedirect;

	always_comb begin
		ctl.ifWr = advance;
		ctl.idWr = advance;
		ctl.exWr = advance;
		ctl.mem1Wr = advance;
		ctl.mem2Wr = advance;
		ctl.wbWr = 1'b1;        // takes a bubble while stalled
		ctl.ifFlush = trapFlush;
		ctl.idFlush = trapFlush;
		ctl.exFlush = trapFlush;
		ctl.mem1Flush = trapFlush;
		ctl.mem2Flush = trapFlush;
		ctl.wbFlush = 1'b0;     // trapping instr still commits
	end

	// MEM2 is empty right after a trap or eret flush
	assert property (@(posedge clk) disable iff (reset)
		trapFlush |=> !trapRedirect)
		else $error("redirect in MEM2 survived a flush");

endmodule

/* verilog/exceptionUnit.sv */
`timescale 1ns/1ns

module exceptionUnit import spinePkg::*; #(
	parameter logic [31:0] EXC_VECTOR = 32'hbfc00380
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input pipeInstr_t mem2Instr,
	output logic trapRedirect,
	output logic [31:0] trapTarget
);

	logic [31:0] epc;
	logic isTrap;
	logic isEret;

	assign isTrap = mem2Instr.valid && mem2Instr.exc;
	assign isEret = mem2Instr.valid && mem2Instr.cls == CLS_ERET;

	assign trapRedirect = isTrap || isEret;
	assign trapTarget = isTrap ? EXC_VECTOR : epc;   // eret returns to epc

	// restart at the jump when the victim sat in its delay slot
	always_ff @(posedge clk) begin
		if (reset)
			epc <= 32'd0;
		else if (advance && isTrap)
			epc <= mem2Instr.isBD ? mem2Instr.pc - 32'd4 : mem2Instr.pc;
	end

	// decoder turns a faulting eret into a reserved normal instr
	assert property (@(posedge clk) disable iff (reset)
		mem2Instr.valid |-> !(mem2Instr.exc && mem2Instr.cls == CLS_ERET))
		else $error("eret carrying an exception at MEM2, pc %h", mem2Instr.pc);

endmodule

/* verilog/pipeSpine.sv */
`timescale 1ns/1ns

module pipeSpine import spinePkg::*; #(
	parameter logic [31:0] RESET_PC = DEFAULT_RESET_PC,
	parameter logic [31:0] EXC_VECTOR = DEFAULT_EXC_VECTOR
) (
	input logic clk,
	input logic reset,
	output logic [31:0] fetchAddr,
	input logic [31:0] instr,
	input logic icacheValid,
	input logic memStall,
	output logic wbValid,
	output pipeInstr_t wbInstr
);

	stageCtl_t ctl;
	logic advance;
	logic ifBubble;
	logic jumpRedirect;
	logic trapRedirect;
	logic [31:0] jumpTarget;
	logic [31:0] trapTarget;

	fetchSlot_t fetchIn;
	fetchSlot_t ifOut;
	pipeInstr_t idIn;
	pipeInstr_t idOut;
	pipeInstr_t exOut;
	pipeInstr_t mem1Out;
	pipeInstr_t mem2Out;
	pipeInstr_t wbIn;

	nextPc #(
		.RESET_PC(RESET_PC),
		.EXC_VECTOR(EXC_VECTOR)
	) pcGen (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.icacheValid(icacheValid),
		.jumpRedirect(jumpRedirect),
		.jumpTarget(jumpTarget),
		.trapRedirect(trapRedirect),
		.trapTarget(trapTarget),
		.fetchAddr(fetchAddr)
	);

	pipeControl ctrl (
		.clk(clk),
		.reset(reset),
		.memStall(memStall),
		.icacheValid(icacheValid),
		.jumpRedirect(jumpRedirect),
		.trapRedirect(trapRedirect),
		.ctl(ctl),
		.advance(advance),
		.ifBubble(ifBubble)
	);

	// icache data is combinational on fetchAddr
	always_comb begin
		fetchIn = '0;
		if (!ifBubble) begin
			fetchIn.valid = 1'b1;
			fetchIn.pc = fetchAddr;
			fetchIn.instr = instr;
		end
	end

	stageReg #(.payload_t(fetchSlot_t)) ifReg (
		.clk(clk), .reset(reset), .wr(ctl.ifWr), .flush(ctl.ifFlush),
		.d(fetchIn), .q(ifOut)
	);

	instrDecode decode (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.trapRedirect(trapRedirect),
		.slot(ifOut),
		.idInstr(idOut),
		.decoded(idIn),
		.jumpRedirect(jumpRedirect),
		.jumpTarget(jumpTarget)
	);

	stageReg #(.payload_t(pipeInstr_t)) idReg (
		.clk(clk), .reset(reset), .wr(ctl.idWr), .flush(ctl.idFlush),
		.d(idIn), .q(idOut)
	);

	stageReg #(.payload_t(pipeInstr_t)) exReg (
		.clk(clk), .reset(reset), .wr(ctl.exWr), .flush(ctl.exFlush),
		.d(idOut), .q(exOut)
	);

	stageReg #(.payload_t(pipeInstr_t)) mem1Reg (
		.clk(clk), .reset(reset), .wr(ctl.mem1Wr), .flush(ctl.mem1Flush),
		.d(exOut), .q(mem1Out)
	);

	stageReg #(.payload_t(pipeInstr_t)) mem2Reg (
		.clk(clk), .reset(reset), .wr(ctl.mem2Wr), .flush(ctl.mem2Flush),
		.d(mem1Out), .q(mem2Out)
	);

	exceptionUnit #(
		.EXC_VECTOR(EXC_VECTOR)
	) excUnit (
		.clk(clk),
		.reset(reset),
		.advance(advance),
		.mem2Instr(mem2Out),
		.trapRedirect(trapRedirect),
		.trapTarget(trapTarget)
	);

	// a held MEM2 instr must not commit twice
	always_comb begin
		wbIn = mem2Out;
		wbIn.valid = mem2Out.valid && advance;
	end

	stageReg #(.payload_t(pipeInstr_t)) wbReg (
		.clk(clk), .reset(reset), .wr(ctl.wbWr), .flush(ctl.wbFlush),
		.d(wbIn), .q(wbInstr)
	);

	assign wbValid = wbInstr.valid;

endmodule

/* test/pipeSpineTb.sv */
`timescale 1ns/1ns

module pipeSpineTb import spinePkg::*; ();

	localparam logic [31:0] RESET_PC = DEFAULT_RESET_PC;
	localparam logic [31:0] EXC_VECTOR = DEFAULT_EXC_VECTOR;
	localparam int COMMITS = 400;
	localparam int COMMIT_TIMEOUT = 500;   // cycles allowed between two commits

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [31:0] fetchAddr;
	logic [31:0] instr;
	logic icacheValid;
	logic memStall;
	logic wbValid;
	pipeInstr_t wbInstr;

	logic [31:0] progMem [0:255];
	integer seed = 32'h88c4db0c;
	logic [31:0] stimBits;
	logic stallAtEdge = 1'b0;   // memStall as seen by the last rising edge
	int commitCount = 0;
	int waited;
	pipeInstr_t expCommit;

	// ISA-level model state
	logic [31:0] refPc = RESET_PC;
	logic [31:0] refEpc = 32'd0;
	logic refInSlot = 1'b0;       // next instr is a delay slot
	logic [31:0] refTarget = 32'd0;

	pipeSpine #(
		.RESET_PC(RESET_PC),
		.EXC_VECTOR(EXC_VECTOR)
	) UUT (
		.clk(clk),
		.reset(reset),
		.fetchAddr(fetchAddr),
		.instr(instr),
		.icacheValid(icacheValid),
		.memStall(memStall),
		.wbValid(wbValid),
		.wbInstr(wbInstr)
	);

	always #2 clk = ~clk;

	// random words bent into the instruction classes at fixed weights
	task automatic fillProgram();
		logic [31:0] raw;
		logic [31:0] pickBits;
		logic [4:0] pick;
		logic [8:0] idx;
		for (idx = 9'd0; idx < 9'd256; idx++) begin
			raw = $random(seed);
			pickBits = $random(seed);
			pick = pickBits[4:0];
			if (pick < 5'd22)
				progMem[idx[7:0]] = {3'b100, raw[28:0]};   // plain load opcodes
			else if (pick < 5'd26)
				progMem[idx[7:0]] = {6'b000010, RESET_PC[27:10], raw[7:0]};
			else if (pick < 5'd28)
				progMem[idx[7:0]] = {6'b010000, raw[25:6], 6'b011000};
			else if (pick < 5'd30)
				progMem[idx[7:0]] = {6'b000000, raw[25:6], 6'b001100};
			else
				progMem[idx[7:0]] = {6'b111111, raw[25:0]};
		end
	endtask

	// one ISA step returning what should commit next
	function automatic pipeInstr_t nextCommit();
		pipeInstr_t c;
		logic [31:0] word;
		logic [31:0] pcPlus4;
		word = progMem[refPc[9:2]];
		pcPlus4 = refPc + 32'd4;
		c = '0;
		c.valid = 1'b1;
		c.pc = refPc;
		c.isBD = refInSlot;
		c.cls = CLS_NORMAL;
		if (word[31:26] == 6'b000010)
			c.cls = CLS_JUMP;
		else if (word[31:26] == 6'b010000 && word[5:0] == 6'b011000)
			c.cls = CLS_ERET;
		else if (word[31:26] == 6'b000000 && word[5:0] == 6'b001100)
			c.cls = CLS_SYSCALL;
		else if (word[31:26] == 6'b111111)
			c.exc = 1'b1;
		// control transfer inside a delay slot is reserved
		if (refInSlot && (c.cls == CLS_JUMP || c.cls == CLS_ERET)) begin
			c.cls = CLS_NORMAL;
			c.exc = 1'b1;
		end
		if (c.cls == CLS_SYSCALL) begin
			c.exc = 1'b1;
			c.excCode = EXC_SYS;
		end else if (c.exc) begin
			c.excCode = EXC_RI;
		end

		if (c.exc) begin
			refEpc = refInSlot ? refPc - 32'd4 : refPc;
			refPc = EXC_VECTOR;
			refInSlot = 1'b0;
		end else if (c.cls == CLS_ERET) begin
			refPc = refEpc;
		end else if (c.cls == CLS_JUMP) begin
			refTarget = {pcPlus4[31:28], word[25:0], 2'b00};
			refPc = pcPlus4;
			refInSlot = 1'b1;
		end else if (refInSlot) begin
			refPc = refTarget;
			refInSlot = 1'b0;
		end else begin
			refPc = pcPlus4;
		end
		return c;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			$display("=== FAIL ===");
			$fatal(1, "mismatch in the commit stream");
		end
	endtask

	// all inputs change on the falling edge
	initial begin
		icacheValid = 1'b0;
		memStall = 1'b0;
		instr = 32'd0;
		fillProgram();
		forever begin
			@(negedge clk);
			stimBits = $random(seed);
			icacheValid = stimBits[1:0] != 2'b00;   // 3 in 4 fetches hit
			memStall = stimBits[3:2] == 2'b00;
			instr = progMem[fetchAddr[9:2]];
		end
	end

	always @(posedge clk)
		stallAtEdge <= memStall;

	// outputs have settled half a cycle after the edge
	always @(negedge clk) begin
		if (stallAtEdge)
			checkValue("wbValid after stalled edge", 32'(wbValid), 32'd0);
		if (wbValid) begin
			expCommit = nextCommit();
			checkValue("wbInstr.pc", wbInstr.pc, expCommit.pc);
			checkValue("wbInstr.cls", 32'(wbInstr.cls), 32'(expCommit.cls));
			checkValue("wbInstr.exc", 32'(wbInstr.exc), 32'(expCommit.exc));
			checkValue("wbInstr.excCode", 32'(wbInstr.excCode), 32'(expCommit.excCode));
			checkValue("wbInstr.isBD", 32'(wbInstr.isBD), 32'(expCommit.isBD));
			commitCount++;
		end
	end

	initial begin
		repeat (3) @(negedge clk);
		reset = 1'b0;
		// first cycle out of reset
		checkValue("fetchAddr", fetchAddr, RESET_PC);
		checkValue("wbValid", 32'(wbValid), 32'd0);
		for (int n = 1; n <= COMMITS; n++) begin
			waited = 0;
			while (commitCount < n && waited < COMMIT_TIMEOUT) begin
				@(posedge clk);
				waited++;
			end
			if (commitCount < n) begin
				$display("timed out after %0d cycles waiting for commit %0d",
					COMMIT_TIMEOUT, n);
				$display("=== FAIL ===");
				$fatal(1, "the DUT stopped committing");
			end
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* pipeSpine.f */
verilog/spinePkg.sv
verilog/stageReg.sv
verilog/nextPc.sv
verilog/instrDecode.sv
verilog/pipeControl.sv
verilog/exceptionUnit.sv
verilog/pipeSpine.sv
test/pipeSpineTb.sv

/* Makefile */
TOP = pipeSpineTb
SIM = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): pipeSpine.f $(shell cat pipeSpine.f)
	verilator --binary --timing --assert --top-module $(TOP) -f pipeSpine.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir
